//--- Makefile
TOP = controller_tb

all: run

build:
	verilator --binary --timing --top-module $(TOP) -f files.f -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then exit 1; fi
	@grep -q "Simulation finished: PASS" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f files.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

//--- dv/controller_checker.sv
module controller_checker import ctrl_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  exec_ctrl_t  exec_ctrl,
    input  mem_ctrl_t   mem_ctrl,
    input  logic        w_en_ldr,
    // expectations of the row driven this cycle
    input  logic        exp_valid,
    input  logic [7:0]  exp_row,
    input  logic [31:0] exp_instr,
    input  logic [3:0]  exp_en,
    input  logic [5:0]  exp_fwd,
    input  logic        exp_chk,
    input  logic [5:0]  exp_mem,
    input  logic        exp_ldr,
    output logic        started,
    output int          rows_done,
    output int          rows_failed,
    output int          mismatches
);

    typedef struct packed {
        logic        valid;
        logic [7:0]  row;
        logic [31:0] instr;
        logic [3:0]  en;
        logic [5:0]  fwd;
        logic        chk;
        logic [5:0]  mem;
        logic        ldr;
    } exp_t;

    exp_t incoming;
    exp_t d1;
    exp_t d2;
    exp_t d3;
    exp_t d4;
    int   cyc;
    int   row_err [256];

    assign incoming = {exp_valid, exp_row, exp_instr, exp_en, exp_fwd, exp_chk, exp_mem,
                       exp_ldr};
    assign started  = rst_n && (cyc > 0);

    // delay lines line up each row with its stage latency
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cyc <= 0;
            d1  <= '0;
            d2  <= '0;
            d3  <= '0;
            d4  <= '0;
        end else begin
            cyc <= cyc + 1;
            d1  <= incoming;
            d2  <= d1;
            d3  <= d2;
            d4  <= d3;
        end
    end

    task automatic check_val(input string name, input logic [31:0] expv,
                             input logic [31:0] got, input int row);
        if (got !== expv) begin
            $display("Fail %s expected %h got %h (row %0d)", name, expv, got, row);
            mismatches++;
            if (row >= 0) begin
                row_err[row]++;
            end
        end
    endtask

    task automatic check_exec();
        int         row;
        logic [3:0] en;
        row = d1.valid ? int'(d1.row) : -1;
        en  = d1.valid ? d1.en : 4'b0;
        check_val("en_A", 32'(en[3]), 32'(exec_ctrl.en_A), row);
        check_val("en_B", 32'(en[2]), 32'(exec_ctrl.en_B), row);
        check_val("en_S", 32'(en[1]), 32'(exec_ctrl.en_S), row);
        check_val("sel_shift", 32'(en[0]), 32'(exec_ctrl.sel_shift), row);
        if (d1.valid && d1.chk) begin
            check_val("opcode", 32'(d1.instr[27:21]), 32'(exec_ctrl.opcode), row);
            check_val("rn", 32'(d1.instr[19:16]), 32'(exec_ctrl.rn), row);
            check_val("rs", 32'(d1.instr[11:8]), 32'(exec_ctrl.rs), row);
            check_val("rm", 32'(d1.instr[3:0]), 32'(exec_ctrl.rm), row);
            check_val("imm5", 32'(d1.instr[11:7]), 32'(exec_ctrl.imm5), row);
            check_val("sel_A_in", 32'(d1.fwd[5:4]), 32'(exec_ctrl.sel_A_in), row);
            check_val("sel_B_in", 32'(d1.fwd[3:2]), 32'(exec_ctrl.sel_B_in), row);
            check_val("sel_shift_in", 32'(d1.fwd[1:0]), 32'(exec_ctrl.sel_shift_in), row);
        end
    endtask

    task automatic check_mem();
        int         row;
        logic [5:0] m;
        logic       redirect;
        row = d2.valid ? int'(d2.row) : -1;
        if (cyc == 0) begin
            // reset-vector load in the first cycle
            m = 6'b001000;
        end else begin
            m = d2.valid ? d2.mem : 6'b000001;
        end
        // only a taken branch picks the pc and the branch offset
        redirect = (m[1:0] == pc_branch);
        check_val("w_en1", 32'(m[5]), 32'(mem_ctrl.w_en1), row);
        check_val("mem_w_en", 32'(m[4]), 32'(mem_ctrl.mem_w_en), row);
        check_val("load_pc", 32'(m[3]), 32'(mem_ctrl.load_pc), row);
        check_val("sel_load_LR", 32'(m[2]), 32'(mem_ctrl.sel_load_LR), row);
        check_val("sel_pc", 32'(m[1:0]), 32'(mem_ctrl.sel_pc), row);
        check_val("sel_branch_imm", 32'(redirect), 32'(mem_ctrl.sel_branch_imm), row);
        check_val("sel_A", 32'(redirect), 32'(mem_ctrl.sel_A), row);
        if (d2.valid && d2.chk) begin
            check_val("cond", 32'(d2.instr[31:28]), 32'(mem_ctrl.cond), row);
            check_val("mem opcode", 32'(d2.instr[27:21]), 32'(mem_ctrl.opcode), row);
            check_val("rd", 32'(d2.instr[15:12]), 32'(mem_ctrl.rd), row);
            check_val("shift_op", 32'(d2.instr[6:5]), 32'(mem_ctrl.shift_op), row);
            check_val("imm12", 32'(d2.instr[11:0]), 32'(mem_ctrl.imm12), row);
            check_val("imm24", 32'(d2.instr[23:0]), 32'(mem_ctrl.imm24), row);
        end
    endtask

    // the write-back check closes a row
    task automatic check_wb();
        int row;
        row = d4.valid ? int'(d4.row) : -1;
        check_val("w_en_ldr", 32'(d4.valid && d4.ldr), 32'(w_en_ldr), row);
        if (d4.valid) begin
            rows_done++;
            if (row_err[row] > 0) begin
                rows_failed++;
                $display("row %0d: %0d mismatches", row, row_err[row]);
            end else begin
                $display("row %0d: ok", row);
            end
        end
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            check_exec();
            check_mem();
            check_wb();
        end
    end

endmodule

//--- dv/controller_tb.sv
module controller_tb import ctrl_pkg::*; ();

    typedef struct packed {
        logic [31:0] instr;
        logic [3:0]  nzcv;
        logic [3:0]  en;
        logic [5:0]  fwd;
        logic        chk;
        logic [5:0]  mem;
        logic        ldr;
    } row_t;

    // enables as {en_A, en_B, en_S, sel_shift}
    localparam logic [3:0] EN_NONE = 4'b0000;
    localparam logic [3:0] EN_A    = 4'b1000;
    localparam logic [3:0] EN_AB   = 4'b1100;
    localparam logic [3:0] EN_ALL  = 4'b1111;
    // memory controls as {w_en1, mem_w_en, load_pc, sel_load_LR, sel_pc}
    localparam logic [5:0] MEM_NONE = 6'b000001;
    localparam logic [5:0] MEM_WR   = 6'b100001;
    localparam logic [5:0] MEM_ST   = 6'b010001;
    localparam logic [5:0] MEM_B    = 6'b001010;
    localparam logic [5:0] MEM_BL   = 6'b101110;
    localparam logic [31:0] IDLE_NOP = {4'he, 7'b1110000, 21'h0};

    logic        clk;
    logic        rst_n;
    instr_t      instr_in;
    logic [31:0] status_reg;
    exec_ctrl_t  exec_ctrl;
    mem_ctrl_t   mem_ctrl;
    logic        w_en_ldr;
    logic        exp_valid;
    logic [7:0]  exp_row;
    logic [31:0] exp_instr;
    logic [3:0]  exp_en;
    logic [5:0]  exp_fwd;
    logic        exp_chk;
    logic [5:0]  exp_mem;
    logic        exp_ldr;
    logic        started;
    int          rows_done;
    int          rows_failed;
    int          mismatches;
    row_t        rows[$];

    controller #(.RESET_LOAD_CYCLES(1)) uut (
        .clk(clk), .rst_n(rst_n), .instr_in(instr_in), .status_reg(status_reg),
        .exec_ctrl(exec_ctrl), .mem_ctrl(mem_ctrl), .w_en_ldr(w_en_ldr)
    );

    controller_checker chk (
        .clk(clk), .rst_n(rst_n), .exec_ctrl(exec_ctrl), .mem_ctrl(mem_ctrl),
        .w_en_ldr(w_en_ldr), .exp_valid(exp_valid), .exp_row(exp_row),
        .exp_instr(exp_instr), .exp_en(exp_en), .exp_fwd(exp_fwd), .exp_chk(exp_chk),
        .exp_mem(exp_mem), .exp_ldr(exp_ldr), .started(started),
        .rows_done(rows_done), .rows_failed(rows_failed), .mismatches(mismatches)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic add_row(input logic [3:0] cond, input logic [2:0] cls,
                           input logic [2:0] alu, input logic post, input logic [3:0] rn,
                           input logic [3:0] rd, input logic [11:0] low,
                           input logic [3:0] nzcv, input logic [3:0] en,
                           input logic [5:0] fwd, input logic chk_on,
                           input logic [5:0] mem, input logic ldr);
        row_t r;
        r.instr = {cond, cls, alu, post, 1'b0, rn, rd, low};
        r.nzcv  = nzcv;
        r.en    = en;
        r.fwd   = fwd;
        r.chk   = chk_on;
        r.mem   = mem;
        r.ldr   = ldr;
        rows.push_back(r);
    endtask

    // NOP with random register fields
    task automatic add_filler();
        logic [31:0] rnd;
        rnd = $urandom;
        add_row(cond_al, cls_nop, rnd[2:0], rnd[3], rnd[7:4], rnd[11:8], rnd[23:12],
                rnd[27:24], EN_NONE, 6'b0, 1'b0, MEM_NONE, 1'b0);
    endtask

    task automatic build_table();
        // decode and forwarding from the memory stage
        add_row(cond_al, cls_dp_imm, 3'd4, 0, 4'd1, 4'd2, 12'h005, 4'h0, EN_A, 6'b000000, 1, MEM_WR, 0);
        add_row(cond_al, cls_dp_imm_shift, 3'd2, 0, 4'd2, 4'd3, 12'h184, 4'h0, EN_AB, 6'b010000, 1,
                MEM_WR, 0);
        add_row(cond_al, cls_dp_reg_shift, 3'd1, 0, 4'd5, 4'd6, 12'h317, 4'h0, EN_ALL, 6'b000001, 1,
                MEM_WR, 0);
        add_row(cond_al, cls_ldr, 3'd0, 1, 4'd6, 4'd8, 12'h004, 4'h0, EN_A, 6'b010000, 1, MEM_NONE, 1);
        add_row(cond_al, cls_str, 3'd0, 0, 4'd9, 4'd8, 12'h00a, 4'h0, EN_AB, 6'b000000, 1, MEM_ST, 0);
        add_filler();
        // reads the load three rows back, now in write-back
        add_row(cond_al, cls_dp_imm_shift, 3'd3, 0, 4'd8, 4'd11, 12'h008, 4'h0, EN_AB, 6'b101000, 1,
                MEM_WR, 0);
        // condition codes against nzcv
        add_row(cond_eq, cls_dp_imm, 3'd0, 0, 4'd1, 4'd12, 12'h000, 4'b0000, EN_A, 6'b0, 1, MEM_NONE, 0);
        add_row(cond_eq, cls_str, 3'd0, 0, 4'd1, 4'd2, 12'h003, 4'b0100, EN_AB, 6'b0, 1, MEM_ST, 0);
        add_row(cond_ge, cls_dp_imm, 3'd0, 0, 4'd1, 4'd4, 12'h000, 4'b1000, EN_A, 6'b0, 1, MEM_NONE, 0);
        add_row(cond_ge, cls_dp_imm, 3'd0, 0, 4'd1, 4'd4, 12'h000, 4'b1001, EN_A, 6'b0, 1, MEM_WR, 0);
        add_row(cond_hi, cls_str, 3'd0, 0, 4'd2, 4'd3, 12'h001, 4'b0010, EN_AB, 6'b0, 1, MEM_ST, 0);
        add_row(cond_nv, cls_dp_imm, 3'd0, 0, 4'd1, 4'd5, 12'h000, 4'b1111, EN_A, 6'b0, 1, MEM_NONE, 0);
        add_row(cond_ne, cls_ldr, 3'd0, 0, 4'd1, 4'd9, 12'h000, 4'b0100, EN_A, 6'b0, 1, MEM_NONE, 0);
        // taken B kills the two younger rows
        add_row(cond_al, cls_b, 3'd0, 0, 4'd0, 4'd0, 12'h010, 4'h0, EN_NONE, 6'b0, 1, MEM_B, 0);
        add_row(cond_al, cls_dp_imm, 3'd0, 0, 4'd1, 4'd2, 12'h000, 4'h0, EN_A, 6'b0, 0, MEM_NONE, 0);
        add_row(cond_al, cls_dp_imm, 3'd0, 0, 4'd1, 4'd2, 12'h000, 4'h0, EN_NONE, 6'b0, 0, MEM_NONE, 0);
        // failed branch redirects nothing
        add_row(cond_eq, cls_b, 3'd0, 0, 4'd0, 4'd0, 12'h020, 4'h0, EN_NONE, 6'b0, 1, MEM_NONE, 0);
        add_row(cond_al, cls_dp_imm, 3'd0, 0, 4'd1, 4'd2, 12'h000, 4'h0, EN_A, 6'b0, 1, MEM_WR, 0);
        add_row(cond_al, cls_bl, 3'd0, 0, 4'd0, 4'd0, 12'h040, 4'h0, EN_NONE, 6'b0, 1, MEM_BL, 0);
        add_row(cond_al, cls_dp_imm_shift, 3'd0, 0, 4'd2, 4'd3, 12'h000, 4'h0, EN_AB, 6'b0, 0,
                MEM_NONE, 0);
        add_row(cond_al, cls_str, 3'd0, 0, 4'd1, 4'd2, 12'h000, 4'h0, EN_NONE, 6'b0, 0, MEM_NONE, 0);
        add_row(cond_al, cls_ldr, 3'd0, 0, 4'd3, 4'd7, 12'h000, 4'h0, EN_A, 6'b0, 1, MEM_NONE, 1);
        add_filler();
        add_filler();
        add_row(cond_al, cls_dp_imm, 3'd0, 0, 4'd7, 4'd1, 12'h007, 4'h0, EN_A, 6'b101000, 1, MEM_WR, 0);
    endtask

    initial begin
        int          k;
        int          waited;
        logic        timed_out;
        void'($urandom(76245));
        timed_out  = 1'b0;
        rst_n      = 1'b0;
        instr_in   = IDLE_NOP;
        status_reg = 32'h0;
        exp_valid  = 1'b0;
        exp_row    = 8'h0;
        exp_instr  = 32'h0;
        exp_en     = 4'h0;
        exp_fwd    = 6'h0;
        exp_chk    = 1'b0;
        exp_mem    = 6'h0;
        exp_ldr    = 1'b0;
        build_table();
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        waited = 0;
        while (!started && waited < 10) begin
            @(negedge clk);
            waited++;
        end
        if (!started) begin
            timed_out = 1'b1;
            $display("timeout: controller never left reset");
        end else begin
            @(posedge clk);
            // status of row k-2 lines up with its memory cycle
            for (k = 0; k < rows.size() + 2; k++) begin
                if (k < rows.size()) begin
                    instr_in  <= rows[k].instr;
                    exp_valid <= 1'b1;
                    exp_row   <= 8'(k);
                    exp_instr <= rows[k].instr;
                    exp_en    <= rows[k].en;
                    exp_fwd   <= rows[k].fwd;
                    exp_chk   <= rows[k].chk;
                    exp_mem   <= rows[k].mem;
                    exp_ldr   <= rows[k].ldr;
                end else begin
                    instr_in  <= IDLE_NOP;
                    exp_valid <= 1'b0;
                end
                if (k >= 2) begin
                    status_reg <= {rows[k-2].nzcv, 28'h0};
                end
                @(posedge clk);
            end

            waited = 0;
            while (rows_done < rows.size() && waited < 16) begin
                @(negedge clk);
                waited++;
            end
            if (rows_done < rows.size()) begin
                timed_out = 1'b1;
                $display("timeout: pipeline did not drain all rows");
            end
        end

        $display("tests %0d, passed %0d, failed %0d, mismatches %0d", rows_done,
                 rows_done - rows_failed, rows_failed, mismatches);
        if (timed_out || mismatches != 0 || rows_done != rows.size()) begin
            $display("Simulation finished: FAIL");
        end else begin
            $display("Simulation finished: PASS");
        end
        $finish;
    end

endmodule

//--- files.f
verilog/ctrl_pkg.sv
verilog/pipe_stage.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/load_tail.sv
verilog/controller.sv
dv/controller_checker.sv
dv/controller_tb.sv

//--- verilog/controller.sv
module controller import ctrl_pkg::*; #(
    parameter int RESET_LOAD_CYCLES = 1
) (
    input  logic        clk,
    input  logic        rst_n,
    input  instr_t      instr_in,
    input  logic [31:0] status_reg,
    output exec_ctrl_t  exec_ctrl,
    output mem_ctrl_t   mem_ctrl,
    output logic        w_en_ldr
);

    localparam int CNT_W = (RESET_LOAD_CYCLES > 1) ? $clog2(RESET_LOAD_CYCLES + 1) : 1;

    stage_item_t exec_item;
    mem_ctrl_t   mem_ctrl_raw;
    tail_item_t  mem_tail;
    logic        branch_taken;
    logic [3:0]  mem_rd;
    logic        mem_writes;
    logic [3:0]  wb_rd;
    logic        wb_load;
    logic [CNT_W-1:0] start_cnt;
    logic        start_active;

    execute_stage u_execute (
        .clk       (clk),
        .rst_n     (rst_n),
        .instr_in  (instr_in),
        .flush     (branch_taken),
        .mem_rd    (mem_rd),
        .mem_writes(mem_writes),
        .wb_rd     (wb_rd),
        .wb_load   (wb_load),
        .item      (exec_item),
        .ctrl      (exec_ctrl)
    );

    memory_stage u_memory (
        .clk         (clk),
        .rst_n       (rst_n),
        .item_in     (exec_item),
        .status_reg  (status_reg),
        .ctrl        (mem_ctrl_raw),
        .branch_taken(branch_taken),
        .rd          (mem_rd),
        .writes_rd   (mem_writes),
        .tail        (mem_tail)
    );

    load_tail u_load_tail (
        .clk     (clk),
        .rst_n   (rst_n),
        .tail_in (mem_tail),
        .wb_rd   (wb_rd),
        .wb_load (wb_load),
        .w_en_ldr(w_en_ldr)
    );

    // start sequencer, counts down the reset-vector load
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_cnt <= CNT_W'(RESET_LOAD_CYCLES);
        end else if (start_active) begin
            start_cnt <= start_cnt - 1'b1;
        end
    end

    assign start_active = (start_cnt != '0);

    always_comb begin
        mem_ctrl = mem_ctrl_raw;
        if (start_active) begin
            mem_ctrl.sel_pc  = pc_reset_vector;
            mem_ctrl.load_pc = 1'b1;
        end
    end

endmodule

//--- verilog/ctrl_pkg.sv
package ctrl_pkg;

    // ARM condition field, 1111 treated as never
    typedef enum logic [3:0] {
        cond_eq = 4'b0000,
        cond_ne, cond_cs, cond_cc, cond_mi, cond_pl, cond_vs, cond_vc,
        cond_hi, cond_ls, cond_ge, cond_lt, cond_gt, cond_le, cond_al, cond_nv
    } cond_e;

    // upper three opcode bits
    typedef enum logic [2:0] {
        cls_dp_imm_shift = 3'b000,
        cls_dp_reg_shift = 3'b001,
        cls_dp_imm       = 3'b010,
        cls_ldr          = 3'b011,
        cls_str          = 3'b100,
        cls_b            = 3'b101,
        cls_bl           = 3'b110,
        cls_nop          = 3'b111
    } op_class_e;

    typedef enum logic [1:0] {
        fwd_regfile = 2'b00,
        fwd_mem     = 2'b01,
        fwd_ldr     = 2'b10
    } fwd_sel_e;

    typedef enum logic [1:0] {
        pc_reset_vector = 2'b00,
        pc_sequential   = 2'b01,
        pc_branch       = 2'b10
    } pc_sel_e;

    typedef struct packed {
        cond_e       cond;
        logic [6:0]  opcode;
        logic        s_bit;
        logic [3:0]  rn;
        logic [3:0]  rd;
        logic [11:0] low;
    } instr_t;

    typedef struct packed {
        logic   valid;
        instr_t instr;
    } stage_item_t;

    // load record for the wait and write-back stages
    typedef struct packed {
        logic       valid;
        logic       is_load;
        logic [3:0] rd;
    } tail_item_t;

    localparam stage_item_t stage_bubble = '0;
    localparam tail_item_t  tail_bubble  = '0;

    typedef struct packed {
        logic [6:0] opcode;
        logic [3:0] rn;
        logic [3:0] rs;
        logic [3:0] rm;
        logic [4:0] imm5;
        fwd_sel_e   sel_A_in;
        fwd_sel_e   sel_B_in;
        fwd_sel_e   sel_shift_in;
        logic       sel_shift;
        logic       en_A;
        logic       en_B;
        logic       en_S;
    } exec_ctrl_t;

    typedef struct packed {
        cond_e       cond;
        logic [6:0]  opcode;
        logic [3:0]  rd;
        logic [1:0]  shift_op;
        logic [11:0] imm12;
        logic [23:0] imm24;
        pc_sel_e     sel_pc;
        logic        load_pc;
        logic        sel_branch_imm;
        logic        sel_A;
        logic        sel_B;
        logic [2:0]  ALU_op;
        logic        sel_post_indexing;
        logic        sel_load_LR;
        logic        w_en1;
        logic        mem_w_en;
    } mem_ctrl_t;

    function automatic op_class_e op_class(logic [6:0] opcode);
        return op_class_e'(opcode[6:4]);
    endfunction

    function automatic logic [2:0] alu_field(logic [6:0] opcode);
        return opcode[3:1];
    endfunction

    // views of the low field
    function automatic logic [3:0] rs_of(instr_t i);
        return i.low[11:8];
    endfunction

    function automatic logic [4:0] imm5_of(instr_t i);
        return i.low[11:7];
    endfunction

    function automatic logic [1:0] shift_op_of(instr_t i);
        return i.low[6:5];
    endfunction

    function automatic logic [3:0] rm_of(instr_t i);
        return i.low[3:0];
    endfunction

    // branch offset spans the whole lower word
    function automatic logic [23:0] imm24_of(instr_t i);
        logic [31:0] word;
        word = i;
        return word[23:0];
    endfunction

endpackage

//--- verilog/execute_stage.sv
module execute_stage import ctrl_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  instr_t      instr_in,
    input  logic        flush,
    // destination held in the memory stage
    input  logic [3:0]  mem_rd,
    input  logic        mem_writes,
    // load sitting in write-back
    input  logic [3:0]  wb_rd,
    input  logic        wb_load,
    output stage_item_t item,
    output exec_ctrl_t  ctrl
);

    stage_item_t fetched;
    op_class_e   cls;
    logic        is_dp;
    logic        reads_rm;
    logic        reg_shift;

    // memory stage result wins over the older load
    function automatic fwd_sel_e fwd_for(logic [3:0] src);
        if (mem_writes && mem_rd == src) begin
            return fwd_mem;
        end else if (wb_load && wb_rd == src) begin
            return fwd_ldr;
        end
        return fwd_regfile;
    endfunction

    assign fetched.valid = 1'b1;
    assign fetched.instr = instr_in;

    pipe_stage #(
        .payload_t(stage_item_t)
    ) u_exec_reg (
        .clk   (clk),
        .rst_n (rst_n),
        .flush (flush),
        .d     (fetched),
        .bubble(stage_bubble),
        .q     (item)
    );

    assign cls       = op_class(item.instr.opcode);
    assign is_dp     = (cls == cls_dp_imm_shift) || (cls == cls_dp_reg_shift)
                    || (cls == cls_dp_imm);
    assign reg_shift = (cls == cls_dp_reg_shift);
    assign reads_rm  = (cls == cls_dp_imm_shift) || reg_shift || (cls == cls_str);

    always_comb begin
        ctrl.opcode = item.instr.opcode;
        ctrl.rn     = item.instr.rn;
        ctrl.rs     = rs_of(item.instr);
        ctrl.rm     = rm_of(item.instr);
        ctrl.imm5   = imm5_of(item.instr);

        // register file read ports
        ctrl.en_A      = item.valid && (is_dp || cls == cls_ldr || cls == cls_str);
        ctrl.en_B      = item.valid && reads_rm;
        ctrl.en_S      = item.valid && reg_shift;
        // shift amount from rs, otherwise imm5
        ctrl.sel_shift = item.valid && reg_shift;

        ctrl.sel_A_in     = fwd_for(item.instr.rn);
        ctrl.sel_B_in     = fwd_for(rm_of(item.instr));
        ctrl.sel_shift_in = fwd_for(rs_of(item.instr));
    end

endmodule

//--- verilog/load_tail.sv
module load_tail import ctrl_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  tail_item_t tail_in,
    output logic [3:0] wb_rd,
    output logic       wb_load,
    output logic       w_en_ldr
);

    tail_item_t wait_q;
    tail_item_t wb_q;

    // memory wait, one cycle for the data memory read
    pipe_stage #(
        .payload_t(tail_item_t)
    ) u_wait_reg (
        .clk   (clk),
        .rst_n (rst_n),
        .flush (1'b0),
        .d     (tail_in),
        .bubble(tail_bubble),
        .q     (wait_q)
    );

    // load write-back
    pipe_stage #(
        .payload_t(tail_item_t)
    ) u_wb_reg (
        .clk   (clk),
        .rst_n (rst_n),
        .flush (1'b0),
        .d     (wait_q),
        .bubble(tail_bubble),
        .q     (wb_q)
    );

    // is_load already carries the condition result
    assign wb_load  = wb_q.valid && wb_q.is_load;
    assign wb_rd    = wb_q.rd;
    assign w_en_ldr = wb_load;

endmodule

//--- verilog/memory_stage.sv
module memory_stage import ctrl_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  stage_item_t item_in,
    input  logic [31:0] status_reg,
    output mem_ctrl_t   ctrl,
    output logic        branch_taken,
    // forwarding source for execute
    output logic [3:0]  rd,
    output logic        writes_rd,
    output tail_item_t  tail
);

    stage_item_t held;
    op_class_e   cls;
    logic        cond_ok;
    logic        is_dp;
    logic        is_branch;

    // nzcv is status_reg[31:28]
    function automatic logic cond_pass(cond_e cond, logic [3:0] nzcv);
        logic n;
        logic z;
        logic c;
        logic v;
        n = nzcv[3];
        z = nzcv[2];
        c = nzcv[1];
        v = nzcv[0];
        case (cond)
            cond_eq: return z;
            cond_ne: return !z;
            cond_cs: return c;
            cond_cc: return !c;
            cond_mi: return n;
            cond_pl: return !n;
            cond_vs: return v;
            cond_vc: return !v;
            cond_hi: return c && !z;
            cond_ls: return !c || z;
            cond_ge: return n == v;
            cond_lt: return n != v;
            cond_gt: return !z && (n == v);
            cond_le: return z || (n != v);
            cond_al: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // a taken branch also empties this slot at the next edge
    pipe_stage #(
        .payload_t(stage_item_t)
    ) u_mem_reg (
        .clk   (clk),
        .rst_n (rst_n),
        .flush (branch_taken),
        .d     (item_in),
        .bubble(stage_bubble),
        .q     (held)
    );

    assign cls       = op_class(held.instr.opcode);
    assign cond_ok   = held.valid && cond_pass(held.instr.cond, status_reg[31:28]);
    assign is_dp     = (cls == cls_dp_imm_shift) || (cls == cls_dp_reg_shift)
                    || (cls == cls_dp_imm);
    assign is_branch = (cls == cls_b) || (cls == cls_bl);

    assign branch_taken = cond_ok && is_branch;

    // BL writes the link register, not rd
    assign rd        = held.instr.rd;
    assign writes_rd = cond_ok && is_dp;

    assign tail.valid   = held.valid;
    assign tail.is_load = cond_ok && (cls == cls_ldr);
    assign tail.rd      = held.instr.rd;

    always_comb begin
        ctrl = '0;
        ctrl.cond     = held.instr.cond;
        ctrl.opcode   = held.instr.opcode;
        ctrl.rd       = held.instr.rd;
        ctrl.shift_op = shift_op_of(held.instr);
        ctrl.imm12    = held.instr.low;
        ctrl.imm24    = imm24_of(held.instr);
        ctrl.sel_pc   = pc_sequential;

        if (cond_ok) begin
            ctrl.ALU_op = alu_field(held.instr.opcode);
            case (cls)
                cls_dp_imm_shift, cls_dp_reg_shift: begin
                    ctrl.w_en1 = 1'b1;
                end
                cls_dp_imm: begin
                    ctrl.sel_B = 1'b1;
                    ctrl.w_en1 = 1'b1;
                end
                cls_ldr: begin
                    // register write happens later via w_en_ldr
                    ctrl.sel_B             = 1'b1;
                    ctrl.sel_post_indexing = held.instr.opcode[0];
                end
                cls_str: begin
                    ctrl.sel_B             = 1'b1;
                    ctrl.sel_post_indexing = held.instr.opcode[0];
                    ctrl.mem_w_en          = 1'b1;
                end
                cls_b, cls_bl: begin
                    ctrl.sel_A          = 1'b1;
                    ctrl.sel_pc         = pc_branch;
                    ctrl.load_pc        = 1'b1;
                    ctrl.sel_branch_imm = 1'b1;
                    ctrl.sel_load_LR    = (cls == cls_bl);
                    ctrl.w_en1          = (cls == cls_bl);
                end
                cls_nop: begin
                    // every control stays at its default
                end
            endcase
        end
    end

endmodule

//--- verilog/pipe_stage.sv
module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    // kill the incoming item
    input  logic     flush,
    input  payload_t d,
    // value of an empty slot
    input  payload_t bubble,
    output payload_t q
);

    // no back-pressure, so the register loads every cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q <= bubble;
        end else if (flush) begin
            q <= bubble;
        end else begin
            q <= d;
        end
    end

endmodule
